//--- pgas_settings.svh
/* Build-wide sizes for the PGAS debug path. The flit and USB word width must stay 16 bits
   because the header field layout in pgas_pkg assumes it. */
`ifndef PGAS_SETTINGS_SVH
`define PGAS_SETTINGS_SVH

// USB word and flit content
`define DBG_WORD_W 16

// Wishbone data path
`define WB_DATA_W 32

// Global memory depth, 32-bit words
`define PGAS_MEM_WORDS 1024

// Entries per flit FIFO
`define PGAS_FIFO_DEPTH 4

// Returned by OP_SYS_ID
`define PGAS_SYSTEM_ID 16'hce75

`endif

//--- pgas_pkg.sv
/* Flit types, debug opcodes and header field widths. The header layout is op[15:12],
   len[11:8], tag[7:0], so the three widths must add up to the flit width. */
`default_nettype none

package pgas_pkg;

   // Header fields, MSB first
   localparam int HDR_OP_W  = 4;
   localparam int HDR_LEN_W = 4; // Words following the header
   localparam int HDR_TAG_W = 8; // Echoed back unchanged

   // Same encoding as the 16-bit debug NoC
   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,
      FLIT_HEAD    = 2'b01,
      FLIT_LAST    = 2'b10,
      FLIT_SINGLE  = 2'b11
   } flit_type_e;

   typedef enum logic [HDR_OP_W-1:0] {
      OP_SYS_ID  = 4'd1,
      OP_CTRL_RD = 4'd2,
      OP_CTRL_WR = 4'd3,  // One value word
      OP_MEM_RD  = 4'd4,  // Addr hi, addr lo
      OP_MEM_WR  = 4'd5,  // Addr hi, addr lo, data hi, data lo
      OP_ERROR   = 4'd15  // Reply to anything unknown
   } dbg_op_e;

endpackage

`default_nettype wire

//--- dbg_noc_if.sv
/* One direction of a debug NoC link. A flit moves on every edge with valid and ready high;
   the sender holds valid and the flit stable until then. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

interface dbg_noc_if;
   import pgas_pkg::*;

   flit_type_e             flit_type;
   logic [`DBG_WORD_W-1:0] content;
   logic                   valid;
   logic                   ready; // Only input driven by the receiver

   // Sending side
   modport tx (output flit_type, output content, output valid, input ready);

   // Receiving side
   modport rx (input flit_type, input content, input valid, output ready);

endinterface

`default_nettype wire

//--- wb_bus_if.sv
/* Single-master Wishbone classic bus, no err/rty and no bursts. The master keeps cyc and
   stb up until the one-cycle ack. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

interface wb_bus_if;

   logic [31:0]              adr;   // Byte address
   logic [`WB_DATA_W-1:0]    dat_w;
   logic [`WB_DATA_W-1:0]    dat_r;
   logic [`WB_DATA_W/8-1:0]  sel;   // Byte lanes
   logic                     we;
   logic                     cyc;
   logic                     stb;
   logic                     ack;

   modport master (
      output adr, output dat_w, output sel, output we, output cyc, output stb,
      input  dat_r, input ack
   );

   modport slave (
      input  adr, input dat_w, input sel, input we, input cyc, input stb,
      output dat_r, output ack
   );

endinterface

`default_nettype wire

//--- dbg_flit_fifo.sv
/* Flit FIFO, one clock. Output is registered, so a flit shows up a cycle after it is written;
   ready drops only when full. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module dbg_flit_fifo #(
   parameter int DEPTH = `PGAS_FIFO_DEPTH
) (
   input  logic  clk,
   input  logic  rst_n_i,
   dbg_noc_if.rx in_i,
   dbg_noc_if.tx out_o
);
   import pgas_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   flit_type_e             type_mem    [DEPTH]; // No reset on storage
   logic [`DBG_WORD_W-1:0] content_mem [DEPTH];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [CW-1:0]          count;
   logic                   push;
   logic                   pop;

   // Wrap for any depth, not only powers of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_i.ready      = (count != CW'(DEPTH));
   assign out_o.valid     = (count != '0);
   assign out_o.flit_type = type_mem[rd_ptr];
   assign out_o.content   = content_mem[rd_ptr];

   assign push = in_i.valid && in_i.ready;
   assign pop  = out_o.valid && out_o.ready;

   always_ff @(posedge clk) begin
      if (push) begin
         type_mem[wr_ptr]    <= in_i.flit_type;
         content_mem[wr_ptr] <= in_i.content;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         count <= count + CW'(push) - CW'(pop); // Both at once keeps count
      end
   end

endmodule

`default_nettype wire

//--- dbg_usb_bridge.sv
/* FX2 slave FIFO bridge. Strobes are active high and every command must start with a valid
   header; a bad length field desynchronizes framing until the count runs out. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module dbg_usb_bridge (
   input  logic                   clk,
   input  logic                   rst_n_i,
   // Host to DUT
   input  logic                   fx2_epout_empty_i,
   input  logic [`DBG_WORD_W-1:0] fx2_fd_i,
   output logic                   fx2_slrd_o,
   // DUT to host
   input  logic                   fx2_epin_full_i,
   output logic [`DBG_WORD_W-1:0] fx2_fd_o,
   output logic                   fx2_slwr_o,
   output logic                   fx2_pktend_o,
   // Debug NoC side
   dbg_noc_if.tx                  to_ctrl_o,
   dbg_noc_if.rx                  from_ctrl_i
);
   import pgas_pkg::*;

   logic [HDR_LEN_W-1:0] words_left; // Payload words still due in this packet
   logic [HDR_LEN_W-1:0] hdr_len;
   logic                 at_header;

   // Read side

   assign at_header = (words_left == '0);
   assign hdr_len   = fx2_fd_i[HDR_TAG_W +: HDR_LEN_W]; // Count field of a header word

   // Word on the bus is the flit, valid in the strobe cycle
   assign to_ctrl_o.valid   = !fx2_epout_empty_i;
   assign to_ctrl_o.content = fx2_fd_i;
   assign fx2_slrd_o        = !fx2_epout_empty_i && to_ctrl_o.ready; // Only if link can take it

   always_comb begin
      if (at_header) begin
         to_ctrl_o.flit_type = (hdr_len == '0) ? FLIT_SINGLE : FLIT_HEAD;
      end else if (words_left == HDR_LEN_W'(1)) begin
         to_ctrl_o.flit_type = FLIT_LAST;
      end else begin
         to_ctrl_o.flit_type = FLIT_PAYLOAD;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         words_left <= '0;
      end else if (fx2_slrd_o) begin
         if (at_header)
            words_left <= hdr_len; // Header starts a new packet
         else
            words_left <= words_left - 1'b1;
      end
   end

   // Write side, straight through

   assign from_ctrl_i.ready = !fx2_epin_full_i;
   assign fx2_fd_o          = from_ctrl_i.content;
   assign fx2_slwr_o        = from_ctrl_i.valid && !fx2_epin_full_i; // Never into a full host
   // Commit the packet with its last word
   assign fx2_pktend_o      = fx2_slwr_o &&
                              (from_ctrl_i.flit_type inside {FLIT_LAST, FLIT_SINGLE});

endmodule

`default_nettype wire

//--- dbg_ctrl.sv
/* Debug command decoder with system control register and Wishbone master. One command at a
   time; a memory command issues exactly one single-word Wishbone cycle. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module dbg_ctrl (
   input  logic     clk,
   input  logic     rst_n_i,
   dbg_noc_if.rx    cmd_i,
   dbg_noc_if.tx    rsp_o,
   wb_bus_if.master wb_o,
   output logic     sys_clk_disable_o,
   output logic     cpu_reset_o,
   output logic     cpu_stall_o
);
   import pgas_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      COLLECT,    // Gathering payload words
      MEM_ACCESS, // Wishbone cycle open
      RESPOND,
      ERR_DRAIN   // Swallow payload of an unknown opcode
   } state_e;

   state_e                   state_q;
   dbg_op_e                  op_q;
   dbg_op_e                  cmd_op;
   logic [HDR_TAG_W-1:0]     tag_q;
   logic [4*`DBG_WORD_W-1:0] pay_q;   // Last four payload words, newest at the bottom
   logic [`WB_DATA_W-1:0]    rdata_q;
   logic [2:0]               ctrl_q;  // {stall, cpu reset, halt}
   logic [HDR_LEN_W-1:0]     rsp_idx; // Word of the response being sent
   logic [HDR_LEN_W-1:0]     rsp_len;
   logic                     cmd_take;
   logic                     cmd_end;
   logic                     rsp_take;

   function automatic logic op_known(input dbg_op_e op);
      return op inside {OP_SYS_ID, OP_CTRL_RD, OP_CTRL_WR, OP_MEM_RD, OP_MEM_WR};
   endfunction

   function automatic logic op_is_mem(input dbg_op_e op);
      return op inside {OP_MEM_RD, OP_MEM_WR};
   endfunction

   assign cmd_op   = dbg_op_e'(cmd_i.content[`DBG_WORD_W-1 -: HDR_OP_W]);
   assign cmd_i.ready = (state_q inside {IDLE, COLLECT, ERR_DRAIN});
   assign cmd_take = cmd_i.valid && cmd_i.ready;
   assign cmd_end  = (cmd_i.flit_type inside {FLIT_LAST, FLIT_SINGLE});
   assign rsp_take = rsp_o.valid && rsp_o.ready;

   assign sys_clk_disable_o = ctrl_q[0];
   assign cpu_reset_o       = ctrl_q[1];
   assign cpu_stall_o       = ctrl_q[2];

   // Wishbone master, single cycle per command
   assign wb_o.cyc   = (state_q == MEM_ACCESS);
   assign wb_o.stb   = (state_q == MEM_ACCESS);
   assign wb_o.we    = (op_q == OP_MEM_WR);
   assign wb_o.sel   = '1;
   assign wb_o.adr   = wb_o.we ? pay_q[63:32] : pay_q[31:0]; // Write has data after addr
   assign wb_o.dat_w = pay_q[31:0];

   // Payload words in the reply
   always_comb begin
      case (op_q)
         OP_SYS_ID, OP_CTRL_RD: rsp_len = HDR_LEN_W'(1);
         OP_MEM_RD:             rsp_len = HDR_LEN_W'(2);
         default:               rsp_len = '0;
      endcase
   end

   always_comb begin
      rsp_o.valid   = (state_q == RESPOND);
      rsp_o.content = {op_q, rsp_len, tag_q}; // Header echo
      if (rsp_idx == '0)
         rsp_o.flit_type = (rsp_len == '0) ? FLIT_SINGLE : FLIT_HEAD;
      else
         rsp_o.flit_type = (rsp_idx == rsp_len) ? FLIT_LAST : FLIT_PAYLOAD;
      if (rsp_idx != '0) begin
         case (op_q)
            OP_SYS_ID:  rsp_o.content = `PGAS_SYSTEM_ID;
            OP_CTRL_RD: rsp_o.content = `DBG_WORD_W'(ctrl_q);
            default:    rsp_o.content = (rsp_idx == HDR_LEN_W'(1)) ?
                                        rdata_q[`WB_DATA_W-1 -: `DBG_WORD_W] : // High first
                                        rdata_q[`DBG_WORD_W-1:0];
         endcase
      end
   end

   // Command fields and data
   always_ff @(posedge clk) begin
      if (state_q == IDLE && cmd_take) begin
         op_q  <= op_known(cmd_op) ? cmd_op : OP_ERROR;
         tag_q <= cmd_i.content[HDR_TAG_W-1:0];
      end
      if (state_q == COLLECT && cmd_take)
         pay_q <= {pay_q[3*`DBG_WORD_W-1:0], cmd_i.content};
      if (wb_o.stb && wb_o.ack)
         rdata_q <= wb_o.dat_r; // Harmless on writes
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         ctrl_q  <= 3'b010; // CPU held in reset until the host clears it
         rsp_idx <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (cmd_take && (cmd_i.flit_type inside {FLIT_HEAD, FLIT_SINGLE})) begin
                  if (!op_known(cmd_op))
                     state_q <= (cmd_i.flit_type == FLIT_SINGLE) ? RESPOND : ERR_DRAIN;
                  else if (cmd_i.flit_type == FLIT_HEAD)
                     state_q <= COLLECT;
                  else
                     state_q <= op_is_mem(cmd_op) ? MEM_ACCESS : RESPOND;
               end
            end
            COLLECT: begin
               if (cmd_take && cmd_end) begin
                  if (op_q == OP_CTRL_WR)
                     ctrl_q <= cmd_i.content[2:0]; // Visible next cycle
                  state_q <= op_is_mem(op_q) ? MEM_ACCESS : RESPOND;
               end
            end
            MEM_ACCESS: begin
               if (wb_o.ack) state_q <= RESPOND; // cyc and stb drop after ack
            end
            ERR_DRAIN: begin
               if (cmd_take && cmd_end) state_q <= RESPOND;
            end
            RESPOND: begin
               if (rsp_take) begin
                  if (rsp_idx == rsp_len) begin
                     rsp_idx <= '0;
                     state_q <= IDLE;
                  end else begin
                     rsp_idx <= rsp_idx + 1'b1;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- wb_sram.sv
/* Single-port Wishbone SRAM for global memory. Only address bits above the byte offset and
   below the array size are decoded, so higher addresses alias onto the same words. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module wb_sram #(
   parameter int WORDS = `PGAS_MEM_WORDS
) (
   input  logic    clk,
   input  logic    rst_n_i,
   wb_bus_if.slave wb_i
);
   localparam int AW = $clog2(WORDS);
   localparam int NB = `WB_DATA_W / 8;

   logic [`WB_DATA_W-1:0] mem [WORDS];
   logic [AW-1:0]         idx;
   logic                  ack_q;
   logic                  access;

   assign idx    = wb_i.adr[AW+1:2]; // PGAS truncation
   assign access = wb_i.cyc && wb_i.stb && !ack_q; // Blocks a second ack right after one
   assign wb_i.ack = ack_q;

   always_ff @(posedge clk) begin
      if (access) begin
         wb_i.dat_r <= mem[idx]; // Valid in the ack cycle
         if (wb_i.we) begin
            for (int b = 0; b < NB; b++) begin
               if (wb_i.sel[b]) mem[idx][b*8 +: 8] <= wb_i.dat_w[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

endmodule

`default_nettype wire

//--- system_pgas_top.sv
/* PGAS debug access top. Single clock, split FX2 data buses, all FX2 strobes active high;
   the CPU control outputs are only driven here, no CPU is attached. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module system_pgas_top (
   input  logic                   clk,
   input  logic                   rst_n_i,
   // FX2 slave FIFO
   input  logic                   fx2_epout_empty_i,
   input  logic [`DBG_WORD_W-1:0] fx2_fd_i,
   output logic                   fx2_slrd_o,
   input  logic                   fx2_epin_full_i,
   output logic [`DBG_WORD_W-1:0] fx2_fd_o,
   output logic                   fx2_slwr_o,
   output logic                   fx2_pktend_o,
   // System control
   output logic                   sys_clk_disable_o,
   output logic                   cpu_reset_o,
   output logic                   cpu_stall_o
);

   dbg_noc_if usb_to_fifo ();  // Bridge into inbound FIFO
   dbg_noc_if fifo_to_ctrl (); // Commands
   dbg_noc_if ctrl_to_fifo (); // Responses
   dbg_noc_if fifo_to_usb ();  // Back out to the host
   wb_bus_if  gmem_bus ();     // Global memory

   dbg_usb_bridge u_usb (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .fx2_epout_empty_i (fx2_epout_empty_i),
      .fx2_fd_i          (fx2_fd_i),
      .fx2_slrd_o        (fx2_slrd_o),
      .fx2_epin_full_i   (fx2_epin_full_i),
      .fx2_fd_o          (fx2_fd_o),
      .fx2_slwr_o        (fx2_slwr_o),
      .fx2_pktend_o      (fx2_pktend_o),
      .to_ctrl_o         (usb_to_fifo),
      .from_ctrl_i       (fifo_to_usb)
   );

   dbg_flit_fifo u_fifo_in (.clk(clk), .rst_n_i(rst_n_i), .in_i(usb_to_fifo), .out_o(fifo_to_ctrl));

   dbg_flit_fifo u_fifo_out (.clk(clk), .rst_n_i(rst_n_i), .in_i(ctrl_to_fifo), .out_o(fifo_to_usb));

   dbg_ctrl u_ctrl (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .cmd_i             (fifo_to_ctrl),
      .rsp_o             (ctrl_to_fifo),
      .wb_o              (gmem_bus),
      .sys_clk_disable_o (sys_clk_disable_o),
      .cpu_reset_o       (cpu_reset_o),
      .cpu_stall_o       (cpu_stall_o)
   );

   wb_sram u_gram (.clk(clk), .rst_n_i(rst_n_i), .wb_i(gmem_bus));

endmodule

`default_nettype wire

//--- system_pgas_props.sv
/* FX2 and global memory handshake assertions, bound into the top. Assertions only run
   out of reset, and every failure also bumps fail_cnt. */
`timescale 1ns/1ps
`default_nettype none

module system_pgas_props (
   input logic clk,
   input logic rst_n_i,
   input logic fx2_epout_empty_i,
   input logic fx2_slrd_i,
   input logic fx2_epin_full_i,
   input logic fx2_slwr_i,
   input logic wb_stb_i,
   input logic wb_ack_i
);
   int fail_cnt = 0; // Read by the testbench at the end

   // Never write into a full host FIFO
   slwr_full_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(fx2_slwr_i && fx2_epin_full_i))
   else begin
      $error("slwr high while the host FIFO is full");
      fail_cnt++;
   end

   // Never read from an empty host FIFO
   slrd_empty_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(fx2_slrd_i && fx2_epout_empty_i))
   else begin
      $error("slrd high while the host FIFO is empty");
      fail_cnt++;
   end

   stb_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      (wb_stb_i && !wb_ack_i) |=> wb_stb_i) // Master waits for ack
   else begin
      $error("stb dropped before ack");
      fail_cnt++;
   end

   ack_stb_a: assert property (@(posedge clk) disable iff (!rst_n_i) wb_ack_i |-> wb_stb_i)
   else begin
      $error("ack without stb");
      fail_cnt++;
   end

endmodule

bind system_pgas_top system_pgas_props u_props (
   .clk               (clk),
   .rst_n_i           (rst_n_i),
   .fx2_epout_empty_i (fx2_epout_empty_i),
   .fx2_slrd_i        (fx2_slrd_o),
   .fx2_epin_full_i   (fx2_epin_full_i),
   .fx2_slwr_i        (fx2_slwr_o),
   .wb_stb_i          (gmem_bus.stb),
   .wb_ack_i          (gmem_bus.ack)
);

`default_nettype wire

//--- tb_checker.sv
/* Reference model and response checker on the FX2 pins. Assumes responses come back in
   command order, one packet per command, and commands carry at most 15 payload words. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module tb_checker (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   empty_i,
   input  logic                   slrd_i,    // Command word taken
   input  logic [`DBG_WORD_W-1:0] rd_data_i,
   input  logic                   slwr_i,    // Response word written
   input  logic [`DBG_WORD_W-1:0] wr_data_i,
   input  logic                   pktend_i,
   input  int                     test_id_i,
   output int                     value_errs_o,
   output int                     other_errs_o,
   output int                     rsp_pkts_o,
   output int                     pending_o
);
   import pgas_pkg::*;

   logic [`DBG_WORD_W-1:0] cmd_w [16];          // Header plus payload of one command
   int                     cmd_n = 0;
   logic [`DBG_WORD_W:0]   exp_q [$];           // {pktend, word}
   int                     exp_tid [$];
   logic [`DBG_WORD_W:0]   exp_e;
   int                     exp_t;
   logic [2:0]             ctrl_m = 3'b010;     // {stall, cpu reset, halt} after reset
   logic [31:0]            gmem_m [`PGAS_MEM_WORDS];
   int                     value_errs = 0;
   int                     other_errs = 0;
   int                     rsp_pkts = 0;

   assign value_errs_o = value_errs;
   assign other_errs_o = other_errs;
   assign rsp_pkts_o   = rsp_pkts;

   function automatic string test_label(input int id);
      case (id)
         0: return "reset";
         1: return "sys_id";
         2: return "ctrl";
         3: return "mem";
         4: return "bad_op";
         default: return "stress";
      endcase
   endfunction

   function automatic void expect_word(input logic [15:0] w, input logic last);
      exp_q.push_back({last, w});
      exp_tid.push_back(test_id_i);
   endfunction

   // Model of one complete command held in cmd_w
   function automatic void predict();
      logic [3:0]  op;
      logic [7:0]  tag;
      logic [31:0] adr;
      int          idx;
      op  = cmd_w[0][15:12];
      tag = cmd_w[0][7:0];
      adr = {cmd_w[1], cmd_w[2]};
      idx = int'((adr >> 2) % `PGAS_MEM_WORDS); // Upper bits alias
      case (op)
         OP_SYS_ID: begin
            expect_word({op, 4'd1, tag}, 1'b0);
            expect_word(`PGAS_SYSTEM_ID, 1'b1);
         end
         OP_CTRL_RD: begin
            expect_word({op, 4'd1, tag}, 1'b0);
            expect_word({13'd0, ctrl_m}, 1'b1);
         end
         OP_CTRL_WR: begin
            ctrl_m = cmd_w[1][2:0];
            expect_word({op, 4'd0, tag}, 1'b1);
         end
         OP_MEM_RD: begin
            expect_word({op, 4'd2, tag}, 1'b0);
            expect_word(gmem_m[idx][31:16], 1'b0); // High half first
            expect_word(gmem_m[idx][15:0], 1'b1);
         end
         OP_MEM_WR: begin
            gmem_m[idx] = {cmd_w[3], cmd_w[4]};
            expect_word({op, 4'd0, tag}, 1'b1);
         end
         default: expect_word({OP_ERROR, 4'd0, tag}, 1'b1);
      endcase
   endfunction

   // Collect command words as the DUT takes them
   always @(negedge clk) begin
      if (rst_n_i && slrd_i && !empty_i) begin
         cmd_w[cmd_n] = rd_data_i;
         if (cmd_n == int'(cmd_w[0][11:8])) begin
            predict();
            cmd_n = 0;
         end else begin
            cmd_n++;
         end
      end
   end

   // Compare every word written to the host
   always @(negedge clk) begin
      if (rst_n_i && slwr_i) begin
         if (exp_q.size() == 0) begin
            $display("response word %h arrived with no command waiting for it", wr_data_i);
            other_errs++;
         end else begin
            exp_e = exp_q.pop_front();
            exp_t = exp_tid.pop_front();
            if (wr_data_i !== exp_e[15:0]) begin
               $display("error %s: expected %h actual %h", test_label(exp_t), exp_e[15:0],
                        wr_data_i);
               value_errs++;
            end
            if (pktend_i !== exp_e[16]) begin
               $display("error %s pktend: expected %b actual %b", test_label(exp_t),
                        exp_e[16], pktend_i);
               value_errs++;
            end
         end
         if (pktend_i) rsp_pkts++; // One per response packet
      end
   end

   always @(posedge clk) pending_o <= exp_q.size();

endmodule

`default_nettype wire

//--- tb_system_pgas.sv
/* Testbench for the PGAS debug path. Host model feeds command words through the FX2 pins,
   random gaps and full cycles come from a fixed seed. */
`timescale 1ns/1ps
`default_nettype none
`include "pgas_settings.svh"

module tb_system_pgas;
   import pgas_pkg::*;

   localparam int CMD_BUDGET     = 250;             // About 200 issued plus margin
   localparam int TIMEOUT_CYCLES = CMD_BUDGET * 60; // Worst case per command

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   fx2_empty;
   logic [`DBG_WORD_W-1:0] fx2_fd_in;
   logic                   fx2_slrd;
   logic                   fx2_full;
   logic [`DBG_WORD_W-1:0] fx2_fd_out;
   logic                   fx2_slwr;
   logic                   fx2_pktend;
   logic                   clk_dis;
   logic                   cpu_rst;
   logic                   cpu_stall;
   logic [`DBG_WORD_W-1:0] cmd_q [$];  // Words the host still has to send
   logic                   took = 1'b0;
   integer                 seed = 32'h4022;
   int                     gap_pct = 0;  // Chance of an empty cycle
   int                     full_pct = 0; // Chance of a full host FIFO
   int                     cmd_sent = 0;
   int                     test_id = 0;
   int                     cycles = 0;
   int                     tb_errs = 0;
   int                     value_errs;
   int                     other_errs;
   int                     rsp_pkts;
   int                     pending;

   always #5 clk = ~clk;

   system_pgas_top uut (
      .clk (clk), .rst_n_i (rst_n),
      .fx2_epout_empty_i (fx2_empty), .fx2_fd_i (fx2_fd_in), .fx2_slrd_o (fx2_slrd),
      .fx2_epin_full_i (fx2_full), .fx2_fd_o (fx2_fd_out), .fx2_slwr_o (fx2_slwr),
      .fx2_pktend_o (fx2_pktend),
      .sys_clk_disable_o (clk_dis), .cpu_reset_o (cpu_rst), .cpu_stall_o (cpu_stall)
   );

   tb_checker u_chk (
      .clk (clk), .rst_n_i (rst_n), .empty_i (fx2_empty), .slrd_i (fx2_slrd),
      .rd_data_i (fx2_fd_in), .slwr_i (fx2_slwr), .wr_data_i (fx2_fd_out),
      .pktend_i (fx2_pktend), .test_id_i (test_id), .value_errs_o (value_errs),
      .other_errs_o (other_errs), .rsp_pkts_o (rsp_pkts), .pending_o (pending)
   );

   // Host FIFOs, a word leaves the queue once the DUT strobed it
   always @(negedge clk) took = fx2_slrd && !fx2_empty;

   always @(posedge clk) begin
      #1;
      if (took) void'(cmd_q.pop_front());
      fx2_full  = ({$random(seed)} % 100) < full_pct;
      fx2_empty = (cmd_q.size() == 0) || (({$random(seed)} % 100) < gap_pct);
      fx2_fd_in = (cmd_q.size() != 0) ? cmd_q[0] : '0;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, rsp_pkts,
                  cmd_sent);
         $display("Something failed");
         $finish;
      end
   end

   // Header, then len payload words from the top of pay
   task automatic send(input logic [3:0] op, input int len, input logic [7:0] tag,
                       input logic [63:0] pay);
      cmd_q.push_back({op, 4'(len), tag});
      for (int i = 0; i < len; i++)
         cmd_q.push_back(pay[63 - 16*i -: 16]);
      cmd_sent++;
   endtask

   task automatic wait_responses();
      while (rsp_pkts < cmd_sent)
         @(posedge clk);
      @(negedge clk); // Outputs settled
   endtask

   task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) begin
         $display("error %s: expected %h actual %h", name, exp, act);
         tb_errs++;
      end
   endtask

   task automatic send_random();
      int          kind;
      logic [31:0] r;
      logic [31:0] adr;
      kind = {$random(seed)} % 6;
      r    = $random(seed);
      adr  = {r[31:12], 6'd0, r[5:2], r[1:0]}; // One of 16 preset words
      case (kind)
         0: send(OP_SYS_ID, 0, r[7:0], '0);
         1: send(OP_CTRL_RD, 0, r[7:0], '0);
         2: send(OP_CTRL_WR, 1, r[7:0], {13'd0, r[10:8], 48'd0});
         3: send(OP_MEM_RD, 2, r[7:0], {adr, 32'd0});
         4: send(OP_MEM_WR, 4, r[7:0], {adr, $random(seed)});
         default: send(4'(6 + r[9:8]), int'(r[11:10]), r[7:0], {r, r}); // Undefined ops
      endcase
   endtask

   initial begin
      rst_n     = 1'b0;
      fx2_empty = 1'b1;
      fx2_fd_in = '0;
      fx2_full  = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      @(negedge clk);
      check_val("reset", 16'h0002, {13'd0, cpu_stall, cpu_rst, clk_dis});
      check_val("reset strobes", 16'h0000, {13'd0, fx2_slrd, fx2_slwr, fx2_pktend});
      test_id = 1;
      send(OP_SYS_ID, 0, 8'h11, '0);
      wait_responses();
      test_id = 2;
      send(OP_CTRL_WR, 1, 8'h21, {16'h0005, 48'd0}); // Halt and stall, CPU out of reset
      wait_responses();
      check_val("ctrl", 16'h0005, {13'd0, cpu_stall, cpu_rst, clk_dis});
      send(OP_CTRL_RD, 0, 8'h22, '0);
      send(OP_CTRL_WR, 1, 8'h23, {16'h0002, 48'd0});
      wait_responses();
      check_val("ctrl", 16'h0002, {13'd0, cpu_stall, cpu_rst, clk_dis});
      send(OP_CTRL_RD, 0, 8'h24, '0);
      wait_responses();
      test_id = 3;
      send(OP_MEM_WR, 4, 8'h31, {32'h0000_0010, 32'hdead_beef});
      send(OP_MEM_RD, 2, 8'h32, {32'h0000_0010, 32'd0});
      send(OP_MEM_WR, 4, 8'h33, {32'h7654_1010, 32'h1234_5678}); // Aliases word 4
      send(OP_MEM_RD, 2, 8'h34, {32'h0000_0010, 32'd0});
      send(OP_MEM_RD, 2, 8'h35, {32'hffff_f013, 32'd0});
      wait_responses();
      test_id = 4;
      send(4'h9, 2, 8'h41, {32'hcafe_f00d, 32'd0});
      send(OP_SYS_ID, 0, 8'h42, '0);
      wait_responses();
      test_id  = 5;
      gap_pct  = 30;
      full_pct = 40;
      for (int i = 0; i < 16; i++)
         send(OP_MEM_WR, 4, 8'(i), {32'(i * 4), $random(seed)}); // Known contents first
      for (int i = 0; i < 150; i++)
         send_random();
      wait_responses();
      repeat (4) @(posedge clk);
      if (pending != 0) begin
         $display("%0d expected response words never arrived", pending);
         tb_errs++;
      end
      $display("errors: %0d response, %0d protocol, %0d testbench, %0d assertion",
               value_errs, other_errs, tb_errs, uut.u_props.fail_cnt);
      if (value_errs + other_errs + tb_errs + uut.u_props.fail_cnt == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
pgas_pkg.sv
dbg_noc_if.sv
wb_bus_if.sv
dbg_flit_fifo.sv
dbg_usb_bridge.sv
dbg_ctrl.sv
wb_sram.sv
system_pgas_top.sv
system_pgas_props.sv
tb_checker.sv
tb_system_pgas.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_system_pgas -f sim.f \
   -o tb_system_pgas || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_system_pgas +verilator+error+limit+1000 2>&1)"
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}
